// ==== logic/arf_pkg.sv ====
package arf_pkg;

   // data path of the architectural register file
   localparam int DATA_WIDTH = 32;
   localparam int REG_COUNT = 32;

   typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
   typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

// ==== logic/rename_pkg.sv ====
package rename_pkg;

   localparam int TAG_WIDTH = 6;   // reorder buffer entry tag
   localparam int SPEC_DEPTH = 5;  // default number of checkpoints

   typedef logic [TAG_WIDTH-1:0] rename_tag_t;

   // one rename table slot holding busy plus the tag of the producing entry
   typedef struct packed {
      logic busy;
      rename_tag_t tag;
   } rename_entry_t;

endpackage

// ==== logic/arch_regfile.sv ====
`timescale 1ns/10ps

module arch_regfile
   import arf_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  reg_idx_t raddr1,
   input  reg_idx_t raddr2,
   output data_t    rdata1,
   output data_t    rdata2,
   input  logic     we,
   input  reg_idx_t waddr,
   input  data_t    wdata
);

   data_t mem [REG_COUNT];

   logic write_ok;

   // register 0 is hardwired so writes to it are dropped
   // no writes land while the core is held in reset
   assign write_ok = we && !reset && (waddr != '0);

   always_ff @(posedge clk) begin
      if (write_ok) begin
         mem[waddr] <= wdata;
      end
   end

   assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];  // x0 reads zero
   assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

// ==== logic/rename_update.sv ====
`timescale 1ns/10ps

module rename_update
   import arf_pkg::*, rename_pkg::*;
#(
   parameter int NUM_SPEC = SPEC_DEPTH
)
(
   input  logic                     disp_we,
   input  reg_idx_t                 disp_reg,
   input  logic [NUM_SPEC-1:0]      disp_freeze,
   input  logic                     com_we,
   input  reg_idx_t                 com_reg,
   input  rename_tag_t              com_tag,
   input  rename_tag_t [NUM_SPEC:0] com_tags_at_reg,
   output logic [NUM_SPEC:0]        set_en,
   output logic [NUM_SPEC:0]        clear_en
);

   logic same_reg;

   // index 0 is the master, index k+1 is checkpoint k
   // a frozen checkpoint keeps its old mapping for this dispatch
   assign set_en = disp_we ? {~disp_freeze, 1'b1} : '0;

   assign same_reg = (disp_reg == com_reg);

   // a commit only retires the newest producer of its register,
   // and a dispatch to the same register in this cycle takes priority
   always_comb begin
      for (int i = 0; i <= NUM_SPEC; i++) begin
         clear_en[i] = com_we
                       && (com_tags_at_reg[i] == com_tag)
                       && !(set_en[i] && same_reg);
      end
   end

endmodule

// ==== logic/rename_checkpoints.sv ====
`timescale 1ns/10ps

module rename_checkpoints
   import arf_pkg::*, rename_pkg::*;
#(
   parameter int NUM_SPEC = SPEC_DEPTH
)
(
   input  logic                     clk,
   input  logic                     reset,
   input  reg_idx_t                 rs1,
   input  reg_idx_t                 rs2,
   output rename_entry_t            rs1_entry,
   output rename_entry_t            rs2_entry,
   input  reg_idx_t                 disp_reg,
   input  rename_tag_t              disp_tag,
   input  reg_idx_t                 com_reg,
   output rename_tag_t [NUM_SPEC:0] com_tags_at_reg,
   input  logic [NUM_SPEC:0]        set_en,
   input  logic [NUM_SPEC:0]        clear_en,
   input  logic                     br_success,
   input  logic                     br_miss,
   input  logic [NUM_SPEC-1:0]      br_spectag
);

   // tbl[0] is the master, tbl[k+1] holds checkpoint k
   rename_entry_t tbl [NUM_SPEC+1][REG_COUNT];

   rename_entry_t master_cleared [REG_COUNT];
   rename_entry_t new_entry;

   logic sel_hit;
   int   sel_idx;   // checkpoint named by br_spectag

   // one-hot spectag to array index
   always_comb begin
      sel_hit = 1'b0;
      sel_idx = 0;
      for (int k = 0; k < NUM_SPEC; k++) begin
         if (br_spectag[k]) begin
            sel_hit = 1'b1;
            sel_idx = k + 1;
         end
      end
   end

   // master after this cycle's commit is folded into the checkpoint on success
   always_comb begin
      for (int r = 0; r < REG_COUNT; r++) begin
         master_cleared[r] = tbl[0][r];
      end
      if (clear_en[0]) begin
         master_cleared[com_reg].busy = 1'b0;
      end
   end

   assign new_entry = '{busy: 1'b1, tag: disp_tag};

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i <= NUM_SPEC; i++) begin
            for (int r = 0; r < REG_COUNT; r++) begin
               tbl[i][r] <= '0;
            end
         end
      end else if (br_success) begin
         // commits still retire while dispatch is held off
         for (int i = 0; i <= NUM_SPEC; i++) begin
            if (clear_en[i]) begin
               tbl[i][com_reg].busy <= 1'b0;
            end
         end
         if (sel_hit) begin
            for (int r = 0; r < REG_COUNT; r++) begin
               tbl[sel_idx][r] <= master_cleared[r];  // copy tracks master again
            end
         end
      end else if (br_miss) begin
         if (sel_hit) begin
            for (int i = 0; i <= NUM_SPEC; i++) begin
               for (int r = 0; r < REG_COUNT; r++) begin
                  tbl[i][r] <= tbl[sel_idx][r];
               end
            end
         end
      end else begin
         for (int i = 0; i <= NUM_SPEC; i++) begin
            if (clear_en[i]) begin
               tbl[i][com_reg].busy <= 1'b0;
            end
            if (set_en[i]) begin
               tbl[i][disp_reg] <= new_entry;
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i <= NUM_SPEC; i++) begin
         com_tags_at_reg[i] = tbl[i][com_reg].tag;
      end
   end

   assign rs1_entry = tbl[0][rs1];
   assign rs2_entry = tbl[0][rs2];

endmodule

// ==== logic/arf_top.sv ====
`timescale 1ns/10ps

module arf_top
   import arf_pkg::*, rename_pkg::*;
#(
   parameter int NUM_SPEC = SPEC_DEPTH
)
(
   input  logic                clk,
   input  logic                reset,
   input  reg_idx_t            rs1,
   input  reg_idx_t            rs2,
   output data_t               rs1_data,
   output data_t               rs2_data,
   output rename_tag_t         rs1_tag,
   output rename_tag_t         rs2_tag,
   output logic                rs1_busy,
   output logic                rs2_busy,
   input  logic                disp_we,
   input  reg_idx_t            disp_reg,
   input  rename_tag_t         disp_tag,
   input  logic [NUM_SPEC-1:0] disp_freeze,
   input  logic                com_we,
   input  reg_idx_t            com_reg,
   input  data_t               com_data,
   input  rename_tag_t         com_tag,
   input  logic                br_success,
   input  logic                br_miss,
   input  logic [NUM_SPEC-1:0] br_spectag
);

   rename_entry_t            rs1_entry;
   rename_entry_t            rs2_entry;
   rename_tag_t [NUM_SPEC:0] com_tags_at_reg;
   logic [NUM_SPEC:0]        set_en;
   logic [NUM_SPEC:0]        clear_en;

   arch_regfile regfile (
      .clk    (clk),
      .reset  (reset),
      .raddr1 (rs1),
      .raddr2 (rs2),
      .rdata1 (rs1_data),
      .rdata2 (rs2_data),
      .we     (com_we),
      .waddr  (com_reg),
      .wdata  (com_data)
   );

   rename_update #(.NUM_SPEC(NUM_SPEC)) update (
      .disp_we         (disp_we),
      .disp_reg        (disp_reg),
      .disp_freeze     (disp_freeze),
      .com_we          (com_we),
      .com_reg         (com_reg),
      .com_tag         (com_tag),
      .com_tags_at_reg (com_tags_at_reg),
      .set_en          (set_en),
      .clear_en        (clear_en)
   );

   rename_checkpoints #(.NUM_SPEC(NUM_SPEC)) rt (
      .clk             (clk),
      .reset           (reset),
      .rs1             (rs1),
      .rs2             (rs2),
      .rs1_entry       (rs1_entry),
      .rs2_entry       (rs2_entry),
      .disp_reg        (disp_reg),
      .disp_tag        (disp_tag),
      .com_reg         (com_reg),
      .com_tags_at_reg (com_tags_at_reg),
      .set_en          (set_en),
      .clear_en        (clear_en),
      .br_success      (br_success),
      .br_miss         (br_miss),
      .br_spectag      (br_spectag)
   );

   assign rs1_tag  = rs1_entry.tag;
   assign rs1_busy = rs1_entry.busy;
   assign rs2_tag  = rs2_entry.tag;
   assign rs2_busy = rs2_entry.busy;

endmodule

// ==== testbench/arf_checker.sv ====
`timescale 1ns/10ps

module arf_checker
   import rename_pkg::*;
#(
   parameter int NUM_SPEC = SPEC_DEPTH
)
(
   input logic                clk,
   input logic                reset,
   input logic                br_success,
   input logic                br_miss,
   input logic [NUM_SPEC-1:0] br_spectag,
   input logic                rs1_busy,
   input logic                rs2_busy
);

   // one resolution per cycle
   branch_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(br_success && br_miss))
      else $error("br_success and br_miss high in the same cycle");

   spectag_onehot: assert property (@(posedge clk) disable iff (reset)
      (br_success || br_miss) |-> $onehot(br_spectag))
      else $error("br_spectag %h is not one-hot during branch resolution", br_spectag);

   busy_clear_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> (!rs1_busy && !rs2_busy))  // table comes up empty
      else $error("busy output set in the first cycle after reset");

endmodule

bind arf_top arf_checker #(.NUM_SPEC(NUM_SPEC)) chk (
   .clk        (clk),
   .reset      (reset),
   .br_success (br_success),
   .br_miss    (br_miss),
   .br_spectag (br_spectag),
   .rs1_busy   (rs1_busy),
   .rs2_busy   (rs2_busy)
);

// ==== testbench/arf_tb.sv ====
`timescale 1ns/10ps

module arf_tb
   import arf_pkg::*, rename_pkg::*;
();

   localparam int NUM_SPEC = SPEC_DEPTH;
   localparam int RESET_CYCLES = 16;
   localparam int RESET_TIMEOUT = 64;

   logic clk = 1'b0;
   logic reset = 1'b1;

   reg_idx_t            rs1;
   reg_idx_t            rs2;
   data_t               rs1_data;
   data_t               rs2_data;
   rename_tag_t         rs1_tag;
   rename_tag_t         rs2_tag;
   logic                rs1_busy;
   logic                rs2_busy;
   logic                disp_we;
   reg_idx_t            disp_reg;
   rename_tag_t         disp_tag;
   logic [NUM_SPEC-1:0] disp_freeze;
   logic                com_we;
   reg_idx_t            com_reg;
   data_t               com_data;
   rename_tag_t         com_tag;
   logic                br_success;
   logic                br_miss;
   logic [NUM_SPEC-1:0] br_spectag;

   int   errors = 0;
   int   seed = 53905;
   logic released;

   always #20 clk = ~clk;  // 40 ns period

   arf_top #(.NUM_SPEC(NUM_SPEC)) UUT (
      .clk         (clk),
      .reset       (reset),
      .rs1         (rs1),
      .rs2         (rs2),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .rs1_tag     (rs1_tag),
      .rs2_tag     (rs2_tag),
      .rs1_busy    (rs1_busy),
      .rs2_busy    (rs2_busy),
      .disp_we     (disp_we),
      .disp_reg    (disp_reg),
      .disp_tag    (disp_tag),
      .disp_freeze (disp_freeze),
      .com_we      (com_we),
      .com_reg     (com_reg),
      .com_data    (com_data),
      .com_tag     (com_tag),
      .br_success  (br_success),
      .br_miss     (br_miss),
      .br_spectag  (br_spectag)
   );

   function automatic logic [NUM_SPEC-1:0] spec_bit(input int k);
      logic [NUM_SPEC-1:0] m;
      m = '0;
      m[k] = 1'b1;
      return m;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      assert (got === expected) else begin
         errors++;
         $display("error: %s got %h expected %h", name, got, expected);
      end
   endtask

   // strobes are single-cycle
   task automatic release_strobes();
      @(posedge clk);
      disp_we <= 1'b0;
      com_we <= 1'b0;
      br_success <= 1'b0;
      br_miss <= 1'b0;
      br_spectag <= '0;
      disp_freeze <= '0;
   endtask

   task automatic dispatch(input int r, input int t, input logic [NUM_SPEC-1:0] freeze);
      @(posedge clk);
      disp_we <= 1'b1;
      disp_reg <= reg_idx_t'(r);
      disp_tag <= rename_tag_t'(t);
      disp_freeze <= freeze;
      release_strobes();
   endtask

   task automatic commit(input int r, input int t, input data_t d);
      @(posedge clk);
      com_we <= 1'b1;
      com_reg <= reg_idx_t'(r);
      com_tag <= rename_tag_t'(t);
      com_data <= d;
      rs1 <= reg_idx_t'(r);  // watch the written register
      rs2 <= reg_idx_t'(r);
      release_strobes();
   endtask

   task automatic resolve_branch(input logic success, input int k);
      @(posedge clk);
      br_success <= success;
      br_miss <= !success;
      br_spectag <= spec_bit(k);
      release_strobes();
   endtask

   task automatic expect_rename(input int r, input logic busy, input int tag);
      @(posedge clk);
      rs1 <= reg_idx_t'(r);
      rs2 <= reg_idx_t'(r);
      @(negedge clk);
      check_value("rs1_busy", 32'(rs1_busy), 32'(busy));
      check_value("rs2_busy", 32'(rs2_busy), 32'(busy));
      check_value("rs1_tag", 32'(rs1_tag), 32'(rename_tag_t'(tag)));
      check_value("rs2_tag", 32'(rs2_tag), 32'(rename_tag_t'(tag)));
   endtask

   task automatic wait_reset_release(output logic ok);
      int cycles;
      cycles = 0;
      while (reset && cycles < RESET_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      ok = !reset;
   endtask

   task automatic test_reset_state();
      for (int r = 0; r < REG_COUNT; r++) begin
         @(posedge clk);
         rs1 <= reg_idx_t'(r);
         rs2 <= reg_idx_t'(REG_COUNT - 1 - r);
         @(negedge clk);
         check_value("rs1_busy", 32'(rs1_busy), 32'h0);
         check_value("rs2_busy", 32'(rs2_busy), 32'h0);
         check_value("rs1_tag", 32'(rs1_tag), 32'h0);
         check_value("rs2_tag", 32'(rs2_tag), 32'h0);
      end
   endtask

   task automatic test_regfile();
      data_t d;
      for (int r = 1; r < REG_COUNT; r++) begin
         d = $random(seed);
         commit(r, 0, d);
         @(negedge clk);
         check_value("rs1_data", rs1_data, d);
         check_value("rs2_data", rs2_data, d);
      end
      // x0 stays zero
      commit(0, 0, $random(seed));
      @(negedge clk);
      check_value("rs1_data", rs1_data, 32'h0);
      check_value("rs2_data", rs2_data, 32'h0);
   endtask

   task automatic test_dispatch_commit();
      dispatch(5, 'h11, '0);
      expect_rename(5, 1'b1, 'h11);
      commit(5, 'h11, $random(seed));
      expect_rename(5, 1'b0, 'h11);
      // stale commit after a re-dispatch
      dispatch(6, 'h12, '0);
      dispatch(6, 'h13, '0);
      commit(6, 'h12, $random(seed));
      expect_rename(6, 1'b1, 'h13);
      commit(6, 'h13, $random(seed));
      expect_rename(6, 1'b0, 'h13);
   endtask

   task automatic test_collision();
      dispatch(7, 'h20, '0);
      @(posedge clk);
      disp_we <= 1'b1;
      disp_reg <= reg_idx_t'(7);
      disp_tag <= rename_tag_t'('h21);
      com_we <= 1'b1;
      com_reg <= reg_idx_t'(7);
      com_tag <= rename_tag_t'('h20);
      com_data <= $random(seed);
      release_strobes();
      expect_rename(7, 1'b1, 'h21);  // dispatch wins
   endtask

   task automatic test_branch_miss();
      dispatch(10, 'h05, '0);
      dispatch(10, 'h30, spec_bit(2));
      dispatch(11, 'h31, spec_bit(2));
      dispatch(12, 'h32, spec_bit(2));
      commit(10, 'h05, $random(seed));  // only copy 2 still holds tag 05
      expect_rename(10, 1'b1, 'h30);
      resolve_branch(1'b0, 2);
      expect_rename(10, 1'b0, 'h05);
      expect_rename(11, 1'b0, 'h00);
      expect_rename(12, 1'b0, 'h00);
      expect_rename(7, 1'b1, 'h21);
   endtask

   task automatic test_branch_success();
      dispatch(13, 'h35, spec_bit(3));
      // dispatch during success is dropped while the commit still retires
      @(posedge clk);
      br_success <= 1'b1;
      br_spectag <= spec_bit(3);
      disp_we <= 1'b1;
      disp_reg <= reg_idx_t'(15);
      disp_tag <= rename_tag_t'('h37);
      com_we <= 1'b1;
      com_reg <= reg_idx_t'(7);
      com_tag <= rename_tag_t'('h21);
      com_data <= $random(seed);
      release_strobes();
      expect_rename(15, 1'b0, 'h00);
      expect_rename(7, 1'b0, 'h21);
      dispatch(14, 'h36, '0);
      resolve_branch(1'b0, 3);
      expect_rename(13, 1'b1, 'h35);
      expect_rename(14, 1'b1, 'h36);
      expect_rename(7, 1'b0, 'h21);
   endtask

   initial begin
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

   initial begin
      rs1 = '0;
      rs2 = '0;
      disp_we = 1'b0;
      disp_reg = '0;
      disp_tag = '0;
      disp_freeze = '0;
      com_we = 1'b0;
      com_reg = '0;
      com_data = '0;
      com_tag = '0;
      br_success = 1'b0;
      br_miss = 1'b0;
      br_spectag = '0;
      wait_reset_release(released);
      if (!released) begin
         $display("reset was still high after %0d cycles", RESET_TIMEOUT);
         $display("Checks failed");
         $finish;
      end else begin
         test_reset_state();
         test_regfile();
         test_dispatch_commit();
         test_collision();
         test_branch_miss();
         test_branch_success();
         $display("errors: %0d", errors);
         if (errors == 0) begin
            $display("All checks passed");
         end else begin
            $display("Checks failed");
         end
         $finish;
      end
   end

endmodule

// ==== files.f ====
logic/arf_pkg.sv
logic/rename_pkg.sv
logic/arch_regfile.sv
logic/rename_update.sv
logic/rename_checkpoints.sv
logic/arf_top.sv
testbench/arf_checker.sv
testbench/arf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the register file testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module arf_tb -f files.f -o arf_sim

# an aborted run (assertion stop) fails the script too
./obj_dir/arf_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log

if grep -q "Checks failed" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation finished without failures"
